// File: tb/dcache_tag_stim.txt
// op addr way stall hit resp_way set_valid, all hex, one request per line
// op 0 lookup, 1 fill, 2 invalidate, 3 ends the list; stall f means random
0 0123456140 0 0 0 0 0
0 3333333fc0 0 3 0 0 0
0 000000003f 0 f 0 0 0
1 0123456140 1 0 0 1 0
0 012345616a 0 0 1 1 1
0 0abcdef140 0 0 0 0 1
0 0123456240 0 0 0 0 0
1 0abcdef140 2 0 0 2 1
1 1111111140 4 2 0 4 3
1 2222222140 8 0 0 8 7
0 0123456140 0 0 1 1 f
0 0abcdef140 0 0 1 2 f
0 1111111140 0 f 1 4 f
0 2222222140 0 0 1 8 f
2 0abcdef140 2 0 0 2 f
0 0abcdef140 0 0 0 0 d
0 0123456140 0 0 1 1 d
0 1111111140 0 4 1 4 d
0 2222222140 0 0 1 8 d
2 0abcdef140 2 0 0 2 d
1 3333333140 2 0 0 2 d
0 3333333140 0 0 1 2 f
0 0abcdef140 0 0 0 0 f
1 0abcdef240 8 0 0 8 0
0 0abcdef240 0 0 1 8 8
0 0123456240 0 0 0 0 8
2 0123456140 1 0 0 1 f
0 0123456140 0 0 0 0 e
3 0000000000 0 0 0 0 0

// File: vlog.f
design/dcache_cfg_pkg.sv
design/dcache_tag_pkg.sv
design/gated_clk_cell.sv
design/spsram_64x58.sv
design/dcache_tag_array.sv
design/dcache_tag_ctrl.sv
design/dcache_tag_top.sv
tb/dcache_tag_assertions.sv
tb/dcache_tag_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the tag path testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module dcache_tag_tb \
  -Mdir "$BUILD_DIR" -o dcache_tag_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/dcache_tag_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0

// File: tb/dcache_tag_tb.sv
/*
 * Tag path testbench
 * Replays requests from the stimulus file, checks every response,
 * its latency and its behavior under back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_tb
  import dcache_cfg_pkg::*;
  import dcache_tag_pkg::*;
();

  logic                   forever_cpuclk;
  logic                   arst_n;
  logic                   icg_en;
  logic                   scan_en;
  logic                   req_valid;
  logic                   req_ready;
  tag_op_e                req_op;
  logic [PADDR_WIDTH-1:0] req_addr;
  logic [NUM_WAYS-1:0]    req_way;
  logic                   resp_valid;
  logic                   resp_ready;
  logic                   resp_hit;
  logic [NUM_WAYS-1:0]    resp_way;
  logic [NUM_WAYS-1:0]    resp_set_valid;

  // Seven words per record, 36 records at most
  logic [PADDR_WIDTH-1:0] stim_mem [0:255];
  int                     seed;

  dcache_tag_top DUT (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .icg_en         (icg_en),
    .scan_en        (scan_en),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .req_op         (req_op),
    .req_addr       (req_addr),
    .req_way        (req_way),
    .resp_valid     (resp_valid),
    .resp_ready     (resp_ready),
    .resp_hit       (resp_hit),
    .resp_way       (resp_way),
    .resp_set_valid (resp_set_valid)
  );

  // Handshake checks live on the controller
  bind dcache_tag_ctrl dcache_tag_assertions x_tag_assertions (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .resp_valid     (resp_valid),
    .resp_ready     (resp_ready),
    .resp_hit       (resp_hit),
    .resp_way       (resp_way),
    .resp_set_valid (resp_set_valid)
  );

  // 40 ns period
  initial begin
    forever_cpuclk = 1'b0;
    forever #20 forever_cpuclk = ~forever_cpuclk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string what, input logic [PADDR_WIDTH-1:0] actual,
                             input logic [PADDR_WIDTH-1:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("MISMATCH at %0t ns: %s is %0h, expected %0h",
                         $time, what, actual, expected));
    end
  endtask

  // ==============================
  // One request, one response
  // ==============================
  task automatic run_request(input int rec);
    int                  base;
    int                  stall;
    int                  waited;
    int                  edges;
    int                  i;
    logic [NUM_WAYS-1:0] exp_way;
    logic [NUM_WAYS-1:0] exp_set_valid;
    logic                exp_hit;
    base          = rec * 7;
    exp_hit       = stim_mem[base+4][0];
    exp_way       = stim_mem[base+5][NUM_WAYS-1:0];
    exp_set_valid = stim_mem[base+6][NUM_WAYS-1:0];
    // Code f asks for a random stall
    if (stim_mem[base+3] == 'hf) begin
      stall = 1 + int'($unsigned($random(seed)) % 6);
    end else begin
      stall = int'(stim_mem[base+3]);
    end
    @(posedge forever_cpuclk);
    req_valid  <= 1'b1;
    req_op     <= tag_op_e'(stim_mem[base][1:0]);
    req_addr   <= stim_mem[base+1];
    req_way    <= stim_mem[base+2][NUM_WAYS-1:0];
    resp_ready <= (stall == 0);
    waited = 0;
    @(negedge forever_cpuclk);
    while (!req_ready) begin
      if (waited == 50) begin
        fail_run("Timeout: the request was never accepted");
      end
      waited++;
      @(negedge forever_cpuclk);
    end
    // Request transfers on this edge
    @(posedge forever_cpuclk);
    req_valid <= 1'b0;
    edges = 0;
    @(negedge forever_cpuclk);
    while (!resp_valid) begin
      check_value("req_ready while busy", PADDR_WIDTH'(req_ready), '0);
      if (edges == 20) begin
        fail_run("Timeout: no response arrived for the request");
      end
      @(posedge forever_cpuclk);
      edges++;
      @(negedge forever_cpuclk);
    end
    check_value("response latency", PADDR_WIDTH'(edges), PADDR_WIDTH'(2));
    check_value("resp_hit", PADDR_WIDTH'(resp_hit), PADDR_WIDTH'(exp_hit));
    check_value("resp_way", PADDR_WIDTH'(resp_way), PADDR_WIDTH'(exp_way));
    check_value("resp_set_valid", PADDR_WIDTH'(resp_set_valid), PADDR_WIDTH'(exp_set_valid));
    // Held response must not move
    for (i = 0; i < stall; i++) begin
      @(negedge forever_cpuclk);
      check_value("resp_valid in stall", PADDR_WIDTH'(resp_valid), PADDR_WIDTH'(1));
      check_value("resp_hit in stall", PADDR_WIDTH'(resp_hit), PADDR_WIDTH'(exp_hit));
      check_value("resp_way in stall", PADDR_WIDTH'(resp_way), PADDR_WIDTH'(exp_way));
      check_value("resp_set_valid in stall", PADDR_WIDTH'(resp_set_valid),
                  PADDR_WIDTH'(exp_set_valid));
      check_value("req_ready in stall", PADDR_WIDTH'(req_ready), '0);
    end
    if (stall > 0) begin
      @(posedge forever_cpuclk);
      resp_ready <= 1'b1;
    end
    // Transfer edge, idle again right after
    @(posedge forever_cpuclk);
    @(negedge forever_cpuclk);
    check_value("resp_valid after transfer", PADDR_WIDTH'(resp_valid), '0);
    check_value("req_ready after transfer", PADDR_WIDTH'(req_ready), PADDR_WIDTH'(1));
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    int   rec;
    int   waited;
    logic done;
    seed       = 59;
    icg_en     = 1'b1;
    scan_en    = 1'b0;
    arst_n     = 1'b0;
    req_valid  = 1'b0;
    req_op     = OP_LOOKUP;
    req_addr   = '0;
    req_way    = '0;
    resp_ready = 1'b1;
    $readmemh("tb/dcache_tag_stim.txt", stim_mem);
    repeat (10) @(posedge forever_cpuclk);
    arst_n <= 1'b1;
    // Sweep clears every set first
    waited = 0;
    @(negedge forever_cpuclk);
    while (!req_ready) begin
      if (waited == 200) begin
        fail_run("Timeout: req_ready did not rise after reset");
      end
      waited++;
      @(negedge forever_cpuclk);
    end
    rec  = 0;
    done = 1'b0;
    while (!done) begin
      if ($isunknown(stim_mem[rec*7]) || rec >= 36) begin
        fail_run("Stimulus file ends without its end marker");
      end
      // Op code 3 ends the list
      if (stim_mem[rec*7] == 'h3) begin
        done = 1'b1;
      end else begin
        run_request(rec);
        rec++;
      end
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/dcache_tag_assertions.sv
/*
 * Tag controller checks
 * Request and response handshake rules and response latency
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_assertions
  import dcache_cfg_pkg::*;
(
  input logic                forever_cpuclk,
  input logic                arst_n,
  input logic                req_valid,
  input logic                req_ready,
  input logic                resp_valid,
  input logic                resp_ready,
  input logic                resp_hit,
  input logic [NUM_WAYS-1:0] resp_way,
  input logic [NUM_WAYS-1:0] resp_set_valid
);

  // Stalled response holds every field
  resp_hold_a : assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_hit) &&
                                  $stable(resp_way) && $stable(resp_set_valid))
    else $error("response changed while stalled");

  // Response loads two edges after acceptance
  // Sampled values show it from the third edge on
  resp_latency_a : assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    req_valid && req_ready |=> !resp_valid ##1 !resp_valid ##1 resp_valid)
    else $error("response latency is not two cycles");

  // No new request while a response is pending
  busy_a : assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    resp_valid |-> !req_ready)
    else $error("req_ready high with a pending response");

  // Back to idle right after the transfer
  idle_a : assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    resp_valid && resp_ready |=> !resp_valid && req_ready)
    else $error("controller not idle after response transfer");

  // Single way on a hit
  hit_way_a : assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    resp_valid && resp_hit |-> $onehot(resp_way))
    else $error("hit way is not one-hot");

endmodule

`default_nettype wire

// File: design/dcache_tag_top.sv
/*
 * Data cache tag path top
 * Tag controller plus the banked tag array
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_top
  import dcache_cfg_pkg::*;
  import dcache_tag_pkg::*;
(
  input  logic                   forever_cpuclk,
  input  logic                   arst_n,
  input  logic                   icg_en,
  input  logic                   scan_en,
  input  logic                   req_valid,
  output logic                   req_ready,
  input  tag_op_e                req_op,
  input  logic [PADDR_WIDTH-1:0] req_addr,
  input  logic [NUM_WAYS-1:0]    req_way,
  output logic                   resp_valid,
  input  logic                   resp_ready,
  output logic                   resp_hit,
  output logic [NUM_WAYS-1:0]    resp_way,
  output logic [NUM_WAYS-1:0]    resp_set_valid
);

  // Controller to array
  logic                                     tag_cen;
  logic                                     tag_gwen;
  logic [WAY_VEC_WIDTH-1:0]                 tag_wen;
  logic                                     tag_clk_en;
  logic [NUM_WAYS-1:0]                      tag_way;
  logic [INDEX_WIDTH+LINE_OFFSET_WIDTH-1:0] tag_idx;
  logic [WAY_VEC_WIDTH-1:0]                 tag_din;
  logic [WAY_VEC_WIDTH-1:0]                 tag_dout;

  dcache_tag_ctrl x_dcache_tag_ctrl (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .req_valid      (req_valid),
    .req_ready      (req_ready),
    .req_op         (req_op),
    .req_addr       (req_addr),
    .req_way        (req_way),
    .resp_valid     (resp_valid),
    .resp_ready     (resp_ready),
    .resp_hit       (resp_hit),
    .resp_way       (resp_way),
    .resp_set_valid (resp_set_valid),
    .tag_cen        (tag_cen),
    .tag_gwen       (tag_gwen),
    .tag_wen        (tag_wen),
    .tag_clk_en     (tag_clk_en),
    .tag_way        (tag_way),
    .tag_idx        (tag_idx),
    .tag_din        (tag_din),
    .tag_dout       (tag_dout)
  );

  // ==============================
  // Tag storage
  // ==============================
  dcache_tag_array x_dcache_tag_array (
    .forever_cpuclk (forever_cpuclk),
    .icg_en         (icg_en),
    .scan_en        (scan_en),
    .tag_cen        (tag_cen),
    .tag_clk_en     (tag_clk_en),
    .tag_din        (tag_din),
    .tag_gwen       (tag_gwen),
    .tag_idx        (tag_idx),
    .tag_way        (tag_way),
    .tag_wen        (tag_wen),
    .tag_dout       (tag_dout)
  );

endmodule

`default_nettype wire

// File: design/dcache_tag_ctrl.sv
/*
 * Data cache tag controller
 * Valid/ready request and response, reset sweep of all valid bits,
 * tag array sequencing and lookup compare
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_ctrl
  import dcache_cfg_pkg::*;
  import dcache_tag_pkg::*;
(
  input  logic                                     forever_cpuclk,
  input  logic                                     arst_n,
  input  logic                                     req_valid,
  output logic                                     req_ready,
  input  tag_op_e                                  req_op,
  input  logic [PADDR_WIDTH-1:0]                   req_addr,
  input  logic [NUM_WAYS-1:0]                      req_way,
  output logic                                     resp_valid,
  input  logic                                     resp_ready,
  output logic                                     resp_hit,
  output logic [NUM_WAYS-1:0]                      resp_way,
  output logic [NUM_WAYS-1:0]                      resp_set_valid,
  output logic                                     tag_cen,
  output logic                                     tag_gwen,
  output logic [WAY_VEC_WIDTH-1:0]                 tag_wen,
  output logic                                     tag_clk_en,
  output logic [NUM_WAYS-1:0]                      tag_way,
  output logic [INDEX_WIDTH+LINE_OFFSET_WIDTH-1:0] tag_idx,
  output logic [WAY_VEC_WIDTH-1:0]                 tag_din,
  input  logic [WAY_VEC_WIDTH-1:0]                 tag_dout
);

  logic [1:0]               state;
  logic [INDEX_WIDTH-1:0]   sweep_idx;
  // Registered request
  tag_op_e                  op_q;
  logic [PADDR_WIDTH-1:0]   addr_q;
  logic [NUM_WAYS-1:0]      way_q;
  // Array strobes
  logic                     sweep_wr;
  logic                     acc_rd;
  logic                     resp_load;
  logic                     resp_wr;
  logic                     wr_full;
  // Write vectors
  tag_slot_u                din_slot;
  tag_slot_u                wr_mask;
  tag_slot_u [NUM_WAYS-1:0] wen_slots;
  // Read decode
  tag_slot_u [NUM_WAYS-1:0] rd_slots;
  logic [NUM_WAYS-1:0]      set_valid;
  logic [NUM_WAYS-1:0]      hit_vec;

  // ==============================
  // Array access
  // ==============================
  assign sweep_wr  = (state == ST_SWEEP);
  // Every op reads all four ways first
  assign acc_rd    = (state == ST_ACCESS);
  // First RESPOND cycle, data from ACCESS edge on tag_dout
  assign resp_load = (state == ST_RESPOND) && !resp_valid;
  // Fill and invalidate write back on the RESPOND edge
  assign resp_wr   = resp_load && (op_q != OP_LOOKUP);
  assign wr_full   = resp_wr && (op_q == OP_FILL);

  assign tag_clk_en = sweep_wr | acc_rd | resp_wr;
  assign tag_cen    = ~(sweep_wr | acc_rd | resp_wr);
  assign tag_gwen   = ~(sweep_wr | resp_wr);
  // Write touches one way, so the other bank stays gated
  assign tag_way    = resp_wr ? way_q : {NUM_WAYS{1'b1}};
  assign tag_idx    = sweep_wr ? {sweep_idx, {LINE_OFFSET_WIDTH{1'b0}}}
                               : addr_q[INDEX_WIDTH+LINE_OFFSET_WIDTH-1:0];

  always_comb begin
    // Fill sets valid, invalidate and sweep clear it
    din_slot.raw     = '0;
    din_slot.f.valid = wr_full;
    din_slot.f.tag   = addr_q[PADDR_WIDTH-1 -: TAG_WIDTH];
    // Valid bit always, tag only on fill
    wr_mask.raw      = '0;
    wr_mask.f.valid  = 1'b1;
    wr_mask.f.tag    = {TAG_WIDTH{wr_full}};
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (sweep_wr || (resp_wr && way_q[w])) begin
        wen_slots[w].raw = ~wr_mask.raw;
      end else begin
        wen_slots[w].raw = '1;
      end
    end
  end

  assign tag_din = {NUM_WAYS{din_slot.raw}};
  assign tag_wen = wen_slots;

  // ==============================
  // Tag compare
  // ==============================
  assign rd_slots = tag_dout;

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      set_valid[w] = rd_slots[w].f.valid;
      hit_vec[w]   = rd_slots[w].f.valid &&
                     (rd_slots[w].f.tag == addr_q[PADDR_WIDTH-1 -: TAG_WIDTH]);
    end
  end

  // ==============================
  // FSM
  // ==============================
  assign req_ready = (state == ST_IDLE);

  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= ST_SWEEP;
      sweep_idx  <= '0;
      resp_valid <= 1'b0;
    end else begin
      case (state)
        ST_SWEEP: begin
          // One set cleared per cycle
          sweep_idx <= sweep_idx + 1'b1;
          if (sweep_idx == INDEX_WIDTH'(NUM_SETS - 1)) begin
            state <= ST_IDLE;
          end
        end
        ST_IDLE: begin
          if (req_valid) begin
            state <= ST_ACCESS;
          end
        end
        ST_ACCESS: begin
          state <= ST_RESPOND;
        end
        default: begin
          if (resp_load) begin
            resp_valid <= 1'b1;
          end else if (resp_ready) begin
            resp_valid <= 1'b0;
            state      <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // Request and response payload
  always_ff @(posedge forever_cpuclk) begin
    if (req_valid && req_ready) begin
      op_q   <= req_op;
      addr_q <= req_addr;
      way_q  <= req_way;
    end
    if (resp_load) begin
      // Writes report the old valid bits and the written way
      resp_hit       <= (op_q == OP_LOOKUP) && (|hit_vec);
      resp_way       <= (op_q == OP_LOOKUP) ? hit_vec : way_q;
      resp_set_valid <= set_valid;
    end
  end

endmodule

`default_nettype wire

// File: design/dcache_tag_array.sv
/*
 * Data cache tag array
 * Two SRAM banks of two ways each, one clock gate per bank
 * Drops the spare bit of each 30-bit slot on write, restores it as zero on read
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_array
  import dcache_cfg_pkg::*;
  import dcache_tag_pkg::*;
(
  input  logic                                     forever_cpuclk,
  input  logic                                     icg_en,
  input  logic                                     scan_en,
  input  logic                                     tag_cen,
  input  logic                                     tag_clk_en,
  input  logic [WAY_VEC_WIDTH-1:0]                 tag_din,
  input  logic                                     tag_gwen,
  input  logic [INDEX_WIDTH+LINE_OFFSET_WIDTH-1:0] tag_idx,
  input  logic [NUM_WAYS-1:0]                      tag_way,
  input  logic [WAY_VEC_WIDTH-1:0]                 tag_wen,
  output logic [WAY_VEC_WIDTH-1:0]                 tag_dout
);

  // Slot views of the way vectors
  tag_slot_u [NUM_WAYS-1:0] din_slots;
  tag_slot_u [NUM_WAYS-1:0] wen_slots;
  tag_slot_u [NUM_WAYS-1:0] dout_slots;

  // Stored layout, way w at [29*w +: 29]
  logic [NUM_WAYS*STORED_WIDTH-1:0] din_raw;
  logic [NUM_WAYS*STORED_WIDTH-1:0] wen_raw;
  logic [NUM_WAYS*STORED_WIDTH-1:0] dout_raw;

  assign din_slots = tag_din;
  assign wen_slots = tag_wen;
  assign tag_dout  = dout_slots;

  // ==============================
  // Slot packing
  // ==============================
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      // Valid on top, tag below, spare removed
      din_raw[w*STORED_WIDTH +: STORED_WIDTH] =
        {din_slots[w].raw[SLOT_WIDTH-1], din_slots[w].raw[TAG_WIDTH-1:0]};
      wen_raw[w*STORED_WIDTH +: STORED_WIDTH] =
        {wen_slots[w].raw[SLOT_WIDTH-1], wen_slots[w].raw[TAG_WIDTH-1:0]};
      // Spare comes back as zero
      dout_slots[w].raw = {dout_raw[w*STORED_WIDTH+STORED_WIDTH-1], 1'b0,
                           dout_raw[w*STORED_WIDTH +: TAG_WIDTH]};
    end
  end

  // ==============================
  // Banks
  // ==============================
  // Bank 0 has ways 0 and 1, bank 1 has ways 2 and 3
  for (genvar b = 0; b < NUM_WAYS / WAYS_PER_BANK; b++) begin : g_bank
    logic bank_sel;
    logic bank_clk_en;
    logic bank_cen;
    logic bank_clk;

    // Bank runs only when one of its ways is involved
    assign bank_sel    = |tag_way[b*WAYS_PER_BANK +: WAYS_PER_BANK];
    assign bank_clk_en = tag_clk_en & bank_sel;
    assign bank_cen    = tag_cen | ~bank_sel;

    gated_clk_cell x_tag_gated_clk (
      .clk_in    (forever_cpuclk),
      .local_en  (bank_clk_en),
      .module_en (icg_en),
      .scan_en   (scan_en),
      .clk_out   (bank_clk)
    );

    // Stopped clock keeps the last read on Q
    spsram_64x58 x_tag_sram (
      .CLK  (bank_clk),
      .CEN  (bank_cen),
      .GWEN (tag_gwen),
      .A    (tag_idx[INDEX_WIDTH+LINE_OFFSET_WIDTH-1:LINE_OFFSET_WIDTH]),
      .D    (din_raw[b*SRAM_WIDTH +: SRAM_WIDTH]),
      .WEN  (wen_raw[b*SRAM_WIDTH +: SRAM_WIDTH]),
      .Q    (dout_raw[b*SRAM_WIDTH +: SRAM_WIDTH])
    );
  end

endmodule

`default_nettype wire

// File: design/spsram_64x58.sv
/*
 * Single-port SRAM, 64 words by 58 bits
 * Active-low chip enable, global write enable and per-bit write enables
 * Registered read data, one cycle latency
 */
`timescale 1ns/1ps
`default_nettype none

module spsram_64x58
  import dcache_cfg_pkg::*;
(
  input  logic                   CLK,
  input  logic                   CEN,
  input  logic                   GWEN,
  input  logic [INDEX_WIDTH-1:0] A,
  input  logic [SRAM_WIDTH-1:0]  D,
  input  logic [SRAM_WIDTH-1:0]  WEN,
  output logic [SRAM_WIDTH-1:0]  Q
);

  // Storage, powers up unknown
  logic [SRAM_WIDTH-1:0] mem [NUM_SETS];

  // ==============================
  // Access port
  // ==============================
  always_ff @(posedge CLK) begin
    if (!CEN) begin
      if (!GWEN) begin
        // Bit write, low WEN takes D
        // Q keeps the previous read
        mem[A] <= (mem[A] & WEN) | (D & ~WEN);
      end else begin
        Q <= mem[A];
      end
    end
  end

endmodule

`default_nettype wire

// File: design/gated_clk_cell.sv
/*
 * Clock gate cell
 * Latch-based ICG with local, module and scan enables
 */
`timescale 1ns/1ps
`default_nettype none

module gated_clk_cell (
  input  logic clk_in,
  input  logic local_en,
  input  logic module_en,
  input  logic scan_en,
  output logic clk_out
);

  logic en_lat;

  // Enable captured while clock is low
  // Scan forces the gate open
  always_latch begin
    if (!clk_in) begin
      en_lat <= scan_en | (local_en & module_en);
    end
  end

  // Glitch-free since en_lat is frozen during the high phase
  assign clk_out = clk_in & en_lat;

endmodule

`default_nettype wire

// File: design/dcache_tag_pkg.sv
/*
 * Tag path types
 * Way slot union, request operation codes and controller state codes
 */
`default_nettype none

package dcache_tag_pkg;

  import dcache_cfg_pkg::*;

  // One way slot of the 120-bit way vector
  // Controller decodes fields, array sees raw bits
  typedef union packed {
    struct packed {
      logic                 valid;
      // Always zero, dropped by the array
      logic                 spare;
      logic [TAG_WIDTH-1:0] tag;
    } f;
    logic [SLOT_WIDTH-1:0] raw;
  } tag_slot_u;

  // Request operations
  typedef enum logic [1:0] {
    OP_LOOKUP = 2'd0,
    OP_FILL   = 2'd1,
    OP_INVAL  = 2'd2
  } tag_op_e;

  // ==============================
  // Controller FSM encoding
  // ==============================
  localparam logic [1:0] ST_SWEEP   = 2'd0;
  localparam logic [1:0] ST_IDLE    = 2'd1;
  localparam logic [1:0] ST_ACCESS  = 2'd2;
  localparam logic [1:0] ST_RESPOND = 2'd3;

endpackage

`default_nettype wire

// File: design/dcache_cfg_pkg.sv
/*
 * Data cache geometry
 * 4-way, 64 sets, 64-byte lines, 40-bit physical address
 * Tag array word layout shared by RTL and testbench
 */
`default_nettype none

package dcache_cfg_pkg;

  // ==============================
  // Address split
  // ==============================
  // Byte in line is addr[5:0], set is addr[11:6], tag is addr[39:12]
  localparam int PADDR_WIDTH       = 40;
  localparam int LINE_OFFSET_WIDTH = 6;
  localparam int INDEX_WIDTH       = 6;
  localparam int TAG_WIDTH         = 28;

  // ==============================
  // Organization
  // ==============================
  // Set count doubles as reset sweep length
  localparam int NUM_SETS      = 64;
  localparam int NUM_WAYS      = 4;
  localparam int WAYS_PER_BANK = 2;

  // ==============================
  // Tag word widths
  // ==============================
  // Slot on the ctrl/array bus: valid, spare, tag
  localparam int SLOT_WIDTH    = 30;
  // Spare bit is not stored
  localparam int STORED_WIDTH  = 29;
  localparam int SRAM_WIDTH    = 58;
  localparam int WAY_VEC_WIDTH = 120;

endpackage

`default_nettype wire
